// ==== verilog/eval_pkg.sv ====
package eval_pkg;

   // Piece type in bits 2:0 of a square, code 7 is unused
   typedef enum logic [2:0] {
      PIECE_EMPTY  = 3'd0,
      PIECE_PAWN   = 3'd1,
      PIECE_KNIGHT = 3'd2,
      PIECE_BISHOP = 3'd3,
      PIECE_ROOK   = 3'd4,
      PIECE_QUEEN  = 3'd5,
      PIECE_KING   = 3'd6
   } piece_t;

   localparam int PIECE_WIDTH = 4;                // Bit 3 is color, 1 = black
   localparam int BOARD_WIDTH = 64 * PIECE_WIDTH; // Square s at bits s*4 upward

   typedef logic [BOARD_WIDTH-1:0] board_t;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_WAIT_ATTACK,
      ST_WAIT_TERMS,
      ST_WAIT_TAPER,
      ST_WAIT_CLEAR
   } seq_state_t;

   localparam int PHASE_MAX         = 62;                                  // Clamp and divisor
   localparam int TAPER_SCALE_SHIFT = 20;
   localparam int TAPER_RECIP       = (1 << TAPER_SCALE_SHIFT) / PHASE_MAX; // 16912
   localparam int TAPER_LATENCY     = 6;                                   // Pipeline stages

   typedef logic [15:0] material_t;

   // Piece values indexed by piece_t, king and empty count zero
   localparam int unsigned MG_VALUE [8] = '{0, 100, 300, 310, 500, 900, 0, 0};
   localparam int unsigned EG_VALUE [8] = '{0, 120, 280, 300, 520, 950, 0, 0};

   // Pawn structure penalties
   localparam int unsigned DOUBLED_MG  = 10; // Per extra pawn on a file
   localparam int unsigned DOUBLED_EG  = 20;
   localparam int unsigned ISOLATED_MG = 15; // Per pawn with no friendly neighbor file
   localparam int unsigned ISOLATED_EG = 10;

endpackage

// ==== verilog/eval_term_if.sv ====
`timescale 1ns/1ps

interface eval_term_if import eval_pkg::*; #(
   parameter int EVAL_WIDTH = 16
) ();

   board_t                       board; // Captured board
   logic                         start; // One-cycle kick
   logic                         clear; // Drops valid
   logic signed [EVAL_WIDTH-1:0] mg;    // Middlegame score, white positive
   logic signed [EVAL_WIDTH-1:0] eg;    // Endgame score, white positive
   logic                         valid; // Held until clear

   modport seq (output board, start, clear, input mg, eg, valid);

   modport term (input board, start, clear, output mg, eg, valid);

endinterface

// ==== verilog/eval_sequencer.sv ====
`timescale 1ns/1ps

module eval_sequencer import eval_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     board_valid,
   input  logic     is_attacking_done,
   input  logic     clear_eval,
   input  board_t   board_in,
   eval_term_if.seq mat,
   eval_term_if.seq pawn,
   output board_t   board,
   output logic     eval_valid
);

   seq_state_t                           state;
   logic                                 board_valid_r; // Previous board_valid for edge detect
   logic                                 board_edge;
   logic                                 start_q;       // Start pulse to both terms
   logic [$clog2(TAPER_LATENCY)-1:0]     taper_count;   // Cycles spent waiting on the taper
   board_t                               board_q;       // Captured board

   assign board_edge = board_valid && !board_valid_r; // Rising edge only

   assign board      = board_q;
   assign mat.board  = board_q;
   assign pawn.board = board_q;
   assign mat.start  = start_q;
   assign pawn.start = start_q;
   assign mat.clear  = clear_eval; // Terms drop valid on the same clear
   assign pawn.clear = clear_eval;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state         <= ST_IDLE;
         board_valid_r <= 1'b0;
         start_q       <= 1'b0;
         eval_valid    <= 1'b0;
         taper_count   <= '0;
      end
      else
      begin
         board_valid_r <= board_valid;
         start_q       <= 1'b0; // Single cycle unless set below
         case (state)
            ST_IDLE:
               if (board_edge)
                  state <= ST_WAIT_ATTACK;
            ST_WAIT_ATTACK:
               if (is_attacking_done)
               begin
                  start_q <= 1'b1;
                  state   <= ST_WAIT_TERMS;
               end
            ST_WAIT_TERMS:
               if (mat.valid && pawn.valid)
               begin
                  taper_count <= '0;
                  state       <= ST_WAIT_TAPER;
               end
            ST_WAIT_TAPER:
            begin
               taper_count <= taper_count + 1'b1;
               if (taper_count == TAPER_LATENCY - 1) // Pipeline now holds final scores
               begin
                  eval_valid <= 1'b1;
                  state      <= ST_WAIT_CLEAR;
               end
            end
            ST_WAIT_CLEAR:
               if (clear_eval)
               begin
                  eval_valid <= 1'b0;
                  state      <= ST_IDLE;
               end
            default:
               state <= ST_IDLE;
         endcase
      end
   end

   // Board only taken on the edge while idle
   always_ff @(posedge clk)
   begin
      if (state == ST_IDLE && board_edge)
         board_q <= board_in;
   end

endmodule

// ==== verilog/material_eval.sv ====
`timescale 1ns/1ps

module material_eval import eval_pkg::*; #(
   parameter int EVAL_WIDTH = 16
) (
   input  logic      clk,
   input  logic      reset,
   eval_term_if.term term,
   output material_t material_white,
   output material_t material_black
);

   localparam int RANK_BITS = 8 * PIECE_WIDTH; // One rank of squares

   logic                         busy;       // Rank walk in progress
   logic [2:0]                   rank;       // Rank to add next cycle
   logic [2:0]                   cur_rank;   // Rank summed this cycle
   logic [RANK_BITS-1:0]         rank_bits;
   logic signed [EVAL_WIDTH-1:0] rank_mg;    // Signed rank sums
   logic signed [EVAL_WIDTH-1:0] rank_eg;
   material_t                    rank_white; // Per-side middlegame values in this rank
   material_t                    rank_black;
   logic signed [EVAL_WIDTH-1:0] mg_acc;
   logic signed [EVAL_WIDTH-1:0] eg_acc;
   logic                         valid_q;

   assign cur_rank  = term.start ? 3'd0 : rank; // Rank 0 goes in on the start cycle
   assign rank_bits = term.board[cur_rank * RANK_BITS +: RANK_BITS];

   always_comb
   begin
      logic [PIECE_WIDTH-1:0] sq;
      piece_t                 kind;
      rank_mg    = '0;
      rank_eg    = '0;
      rank_white = '0;
      rank_black = '0;
      for (int f = 0; f < 8; f++)
      begin
         sq   = rank_bits[f * PIECE_WIDTH +: PIECE_WIDTH];
         kind = piece_t'(sq[2:0]);
         if (sq[3]) // Black counts against white
         begin
            rank_mg    = rank_mg - EVAL_WIDTH'(MG_VALUE[kind]);
            rank_eg    = rank_eg - EVAL_WIDTH'(EG_VALUE[kind]);
            rank_black = rank_black + material_t'(MG_VALUE[kind]);
         end
         else
         begin
            rank_mg    = rank_mg + EVAL_WIDTH'(MG_VALUE[kind]);
            rank_eg    = rank_eg + EVAL_WIDTH'(EG_VALUE[kind]);
            rank_white = rank_white + material_t'(MG_VALUE[kind]);
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy    <= 1'b0;
         rank    <= 3'd0;
         valid_q <= 1'b0;
      end
      else
      begin
         if (term.start)
         begin
            busy <= 1'b1;
            rank <= 3'd1;
         end
         else if (busy)
         begin
            rank <= rank + 3'd1;
            if (rank == 3'd7) // Last rank added this cycle
            begin
               busy    <= 1'b0;
               valid_q <= 1'b1;
            end
         end
         if (term.clear)
            valid_q <= 1'b0;
      end
   end

   // Accumulators, restarted by start
   always_ff @(posedge clk)
   begin
      if (term.start)
      begin
         mg_acc         <= rank_mg;
         eg_acc         <= rank_eg;
         material_white <= rank_white;
         material_black <= rank_black;
      end
      else if (busy)
      begin
         mg_acc         <= mg_acc + rank_mg;
         eg_acc         <= eg_acc + rank_eg;
         material_white <= material_white + rank_white;
         material_black <= material_black + rank_black;
      end
   end

   assign term.mg    = mg_acc;
   assign term.eg    = eg_acc;
   assign term.valid = valid_q;

endmodule

// ==== verilog/pawn_eval.sv ====
`timescale 1ns/1ps

module pawn_eval import eval_pkg::*; #(
   parameter int EVAL_WIDTH = 16
) (
   input  logic      clk,
   input  logic      reset,
   eval_term_if.term term
);

   logic [7:0][3:0]              white_next; // Pawns per file from the board
   logic [7:0][3:0]              black_next;
   logic [7:0][3:0]              white_cnt;  // Registered file counts
   logic [7:0][3:0]              black_cnt;
   logic                         counted;    // Counts valid for this board
   logic                         valid_q;
   logic signed [EVAL_WIDTH-1:0] mg_q;
   logic signed [EVAL_WIDTH-1:0] eg_q;

   // Doubled and isolated penalty for one side, always positive
   function automatic logic [EVAL_WIDTH-1:0] side_penalty(
      input logic [7:0][3:0] cnt,
      input int unsigned     doubled,
      input int unsigned     isolated
   );
      int unsigned sum;
      logic [7:0]  has;
      logic [7:0]  adj;
      for (int f = 0; f < 8; f++)
         has[f] = (cnt[f] != 4'd0);
      adj = (has << 1) | (has >> 1); // Pawn on file f-1 or f+1
      sum = 0;
      for (int f = 0; f < 8; f++)
      begin
         if (has[f])
         begin
            sum = sum + doubled * (cnt[f] - 1);
            if (!adj[f])
               sum = sum + isolated * cnt[f];
         end
      end
      return EVAL_WIDTH'(sum);
   endfunction

   always_comb
   begin
      logic [PIECE_WIDTH-1:0] sq;
      white_next = '0;
      black_next = '0;
      for (int s = 0; s < 64; s++)
      begin
         sq = term.board[s * PIECE_WIDTH +: PIECE_WIDTH];
         if (piece_t'(sq[2:0]) == PIECE_PAWN)
         begin
            if (sq[3])
               black_next[s % 8] = black_next[s % 8] + 4'd1;
            else
               white_next[s % 8] = white_next[s % 8] + 4'd1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         counted <= 1'b0;
         valid_q <= 1'b0;
      end
      else
      begin
         counted <= term.start;
         if (counted)
            valid_q <= 1'b1;
         if (term.clear)
            valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (term.start)
      begin
         white_cnt <= white_next;
         black_cnt <= black_next;
      end
      if (counted) // White penalty negative, black positive
      begin
         mg_q <= side_penalty(black_cnt, DOUBLED_MG, ISOLATED_MG) -
                 side_penalty(white_cnt, DOUBLED_MG, ISOLATED_MG);
         eg_q <= side_penalty(black_cnt, DOUBLED_EG, ISOLATED_EG) -
                 side_penalty(white_cnt, DOUBLED_EG, ISOLATED_EG);
      end
   end

   assign term.mg    = mg_q;
   assign term.eg    = eg_q;
   assign term.valid = valid_q;

endmodule

// ==== verilog/taper_pipeline.sv ====
`timescale 1ns/1ps

module taper_pipeline import eval_pkg::*; #(
   parameter int EVAL_WIDTH = 16
) (
   input  logic                         clk,
   input  board_t                       board,
   input  logic signed [EVAL_WIDTH-1:0] mat_mg,
   input  logic signed [EVAL_WIDTH-1:0] mat_eg,
   input  logic signed [EVAL_WIDTH-1:0] pawn_mg,
   input  logic signed [EVAL_WIDTH-1:0] pawn_eg,
   output logic signed [EVAL_WIDTH-1:0] eval
);

   localparam int SUM_W    = EVAL_WIDTH + 1; // Two terms added
   localparam int PROD_W   = SUM_W + 7;      // Times phase, signed 7 bits
   localparam int BLEND_W  = PROD_W + 1;
   localparam int SCALED_W = BLEND_W + 16;   // Times the reciprocal
   localparam logic signed [15:0]         RECIP      = 16'(TAPER_RECIP);
   localparam logic signed [SCALED_W-1:0] TRUNC_BIAS = SCALED_W'((1 << TAPER_SCALE_SHIFT) - 1);

   logic [6:0]                 piece_count; // Non-pawn pieces, 0 to 64
   logic [5:0]                 phase_s1;
   logic signed [SUM_W-1:0]    mg_sum_s1;
   logic signed [SUM_W-1:0]    eg_sum_s1;
   logic signed [PROD_W-1:0]   mg_prod_s2;
   logic signed [PROD_W-1:0]   eg_prod_s2;
   logic signed [BLEND_W-1:0]  blend_s3;
   logic signed [SCALED_W-1:0] scaled_s4;
   logic signed [SCALED_W-1:0] quot_s5;

   always_comb
   begin
      piece_t kind;
      piece_count = '0;
      for (int s = 0; s < 64; s++)
      begin
         kind = piece_t'(board[s * PIECE_WIDTH +: 3]);
         if (kind != PIECE_EMPTY && kind != PIECE_PAWN)
            piece_count = piece_count + 7'd1;
      end
   end

   always_ff @(posedge clk)
   begin
      phase_s1   <= (piece_count > PHASE_MAX) ? 6'(PHASE_MAX) : piece_count[5:0]; // Clamp
      mg_sum_s1  <= mat_mg + pawn_mg;
      eg_sum_s1  <= mat_eg + pawn_eg;
      mg_prod_s2 <= mg_sum_s1 * $signed({1'b0, phase_s1});
      eg_prod_s2 <= eg_sum_s1 * $signed({1'b0, 6'(PHASE_MAX) - phase_s1}); // Endgame weight
      blend_s3   <= mg_prod_s2 + eg_prod_s2;
      scaled_s4  <= blend_s3 * RECIP;
      if (scaled_s4 < 0) // Bias negatives so the shift truncates toward zero
         quot_s5 <= (scaled_s4 + TRUNC_BIAS) >>> TAPER_SCALE_SHIFT;
      else
         quot_s5 <= scaled_s4 >>> TAPER_SCALE_SHIFT;
      eval       <= quot_s5[EVAL_WIDTH-1:0];
   end

endmodule

// ==== verilog/eval_top.sv ====
`timescale 1ns/1ps

module eval_top import eval_pkg::*; #(
   parameter int EVAL_WIDTH = 16
) (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         board_valid,
   input  logic                         is_attacking_done,
   input  logic                         clear_eval,
   input  logic [BOARD_WIDTH-1:0]       board_in,
   output logic signed [EVAL_WIDTH-1:0] eval,
   output logic                         eval_valid,
   output material_t                    material_white,
   output material_t                    material_black
);

   board_t board; // Captured board, feeds the phase count

   eval_term_if #(.EVAL_WIDTH(EVAL_WIDTH)) mat_if ();
   eval_term_if #(.EVAL_WIDTH(EVAL_WIDTH)) pawn_if ();

   eval_sequencer u_sequencer (
      .clk               (clk),
      .reset             (reset),
      .board_valid       (board_valid),
      .is_attacking_done (is_attacking_done),
      .clear_eval        (clear_eval),
      .board_in          (board_in),
      .mat               (mat_if),
      .pawn              (pawn_if),
      .board             (board),
      .eval_valid        (eval_valid)
   );

   material_eval #(.EVAL_WIDTH(EVAL_WIDTH)) u_material (
      .clk            (clk),
      .reset          (reset),
      .term           (mat_if),
      .material_white (material_white),
      .material_black (material_black)
   );

   pawn_eval #(.EVAL_WIDTH(EVAL_WIDTH)) u_pawn (
      .clk   (clk),
      .reset (reset),
      .term  (pawn_if)
   );

   // Free-running, sequencer times the result
   taper_pipeline #(.EVAL_WIDTH(EVAL_WIDTH)) u_taper (
      .clk     (clk),
      .board   (board),
      .mat_mg  (mat_if.mg),
      .mat_eg  (mat_if.eg),
      .pawn_mg (pawn_if.mg),
      .pawn_eg (pawn_if.eg),
      .eval    (eval)
   );

endmodule

// ==== tb/eval_props.sv ====
`timescale 1ns/1ps

module eval_props import eval_pkg::*; (
   input logic       clk,
   input logic       reset,
   input seq_state_t state,
   input logic       start,
   input logic       eval_valid,
   input logic       clear_eval
);

   // Start to the terms is one cycle wide
   start_single: assert property (@(posedge clk) disable iff (reset) start |=> !start)
      else $error("start pulse lasted more than one cycle");

   // Result held until clear_eval
   valid_held: assert property (@(posedge clk) disable iff (reset)
      eval_valid && !clear_eval |=> eval_valid)
      else $error("eval_valid fell without clear_eval");

   // No result while idle
   idle_quiet: assert property (@(posedge clk) disable iff (reset)
      state == ST_IDLE |-> !eval_valid)
      else $error("eval_valid high in idle");

endmodule

bind eval_sequencer eval_props u_props (
   .clk        (clk),
   .reset      (reset),
   .state      (state),
   .start      (start_q),
   .eval_valid (eval_valid),
   .clear_eval (clear_eval)
);

// ==== tb/eval_tb.sv ====
`timescale 1ns/1ps

module eval_tb;

   localparam int WAIT_LIMIT = 40; // Cycles allowed for eval_valid

   logic               clk;
   logic               reset;
   logic               board_valid;
   logic               is_attacking_done;
   logic               clear_eval;
   logic [255:0]       board_in;
   logic signed [15:0] eval;
   logic               eval_valid;
   logic [15:0]        material_white;
   logic [15:0]        material_black;

   logic [31:0] rng_state;
   int          value_errors;
   int          timing_errors;
   bit          timed_out;   // Stops further boards

   eval_top #(.EVAL_WIDTH(16)) DUT (.*);

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk; // 4 ns period
   end

   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   // Random board, full ones hold only non-pawn pieces plus maybe one pawn
   function automatic logic [255:0] random_board(input bit full);
      logic [255:0] b;
      logic [31:0]  density;
      logic [31:0]  r;
      density = next_rand() % 101; // Percent of squares occupied
      for (int s = 0; s < 64; s++)
      begin
         r = next_rand();
         if (full)
            b[s*4 +: 3] = 3'(2 + r % 5);
         else if ((r % 100) < density)
            b[s*4 +: 3] = 3'(1 + (r >> 8) % 6);
         else
            b[s*4 +: 3] = 3'd0;
         b[s*4 + 3] = r[20]; // Color, also set on empty squares
      end
      r = next_rand();
      if (full && r[0])
         b[(r[8:3])*4 +: 3] = 3'd1; // Still 63 non-pawns
      return b;
   endfunction

   function automatic int piece_value(input logic [2:0] kind, input bit endgame);
      case (kind)
         3'd1:    return endgame ? 120 : 100;
         3'd2:    return endgame ? 280 : 300;
         3'd3:    return endgame ? 300 : 310;
         3'd4:    return endgame ? 520 : 500;
         3'd5:    return endgame ? 950 : 900;
         default: return 0; // King and empty
      endcase
   endfunction

   // One side's doubled plus isolated penalty
   function automatic int pawn_penalty(input int cnt [8], input int doubled, input int isolated);
      int p;
      int left;
      int right;
      p = 0;
      for (int f = 0; f < 8; f++)
      begin
         left  = (f > 0) ? cnt[f-1] : 0;
         right = (f < 7) ? cnt[f+1] : 0;
         if (cnt[f] > 0)
         begin
            p = p + doubled * (cnt[f] - 1);
            if (left == 0 && right == 0)
               p = p + isolated * cnt[f];
         end
      end
      return p;
   endfunction

   task automatic model_eval(input logic [255:0] b, output int exp_white,
                             output int exp_black, output int exp_eval);
      int         mg;
      int         eg;
      int         phase;
      int         wcnt [8];
      int         bcnt [8];
      logic [2:0] kind;
      longint     blend;
      mg = 0;
      eg = 0;
      phase = 0;
      exp_white = 0;
      exp_black = 0;
      for (int f = 0; f < 8; f++)
      begin
         wcnt[f] = 0;
         bcnt[f] = 0;
      end
      for (int s = 0; s < 64; s++)
      begin
         kind = b[s*4 +: 3];
         if (kind != 3'd0 && kind != 3'd1)
            phase++;                // Non-pawn piece
         if (b[s*4 + 3])
         begin
            mg = mg - piece_value(kind, 0);
            eg = eg - piece_value(kind, 1);
            exp_black = exp_black + piece_value(kind, 0);
            if (kind == 3'd1)
               bcnt[s % 8]++;
         end
         else
         begin
            mg = mg + piece_value(kind, 0);
            eg = eg + piece_value(kind, 1);
            exp_white = exp_white + piece_value(kind, 0);
            if (kind == 3'd1)
               wcnt[s % 8]++;
         end
      end
      mg = mg + pawn_penalty(bcnt, 10, 15) - pawn_penalty(wcnt, 10, 15); // White penalized
      eg = eg + pawn_penalty(bcnt, 20, 10) - pawn_penalty(wcnt, 20, 10);
      if (phase > 62)
         phase = 62;
      blend = longint'(mg) * phase + longint'(eg) * (62 - phase);
      exp_eval = int'((blend * 16912) / 64'sd1048576); // Division truncates toward zero
   endtask

   task automatic check_outputs(input int exp_white, input int exp_black, input int exp_eval);
      if (eval !== 16'(exp_eval))
      begin
         value_errors++;
         $display("FAIL eval: got %h, expected %h", eval, 16'(exp_eval));
      end
      if (material_white !== 16'(exp_white))
      begin
         value_errors++;
         $display("FAIL material_white: got %h, expected %h", material_white, 16'(exp_white));
      end
      if (material_black !== 16'(exp_black))
      begin
         value_errors++;
         $display("FAIL material_black: got %h, expected %h", material_black, 16'(exp_black));
      end
   endtask

   // One full evaluation, with noise on board_in and board_valid while busy
   task automatic run_board(input logic [255:0] b);
      int exp_white;
      int exp_black;
      int exp_eval;
      int delay;
      int hold;
      int cycles;
      model_eval(b, exp_white, exp_black, exp_eval);
      @(negedge clk);
      board_in    = b;
      board_valid = 1'b1;
      @(negedge clk);
      board_valid = 1'b0;
      board_in    = random_board(0);   // Must not reach the result
      delay       = next_rand() % 21;
      for (int i = 0; i < delay; i++)
      begin
         board_valid = (i == 1);       // Edge while busy
         @(negedge clk);
         if (eval_valid)
         begin
            timing_errors++;
            $display("eval_valid rose before is_attacking_done was given");
         end
      end
      board_valid       = 1'b0;
      is_attacking_done = 1'b1;
      @(negedge clk);
      is_attacking_done = 1'b0;
      cycles = 0;
      while (!eval_valid && cycles < WAIT_LIMIT)
      begin
         board_in = random_board(0);
         @(negedge clk);
         cycles++;
      end
      if (!eval_valid)
      begin
         timing_errors++;
         timed_out = 1'b1;
         $display("Timeout: eval_valid did not rise within %0d cycles", WAIT_LIMIT);
      end
      else
      begin
         check_outputs(exp_white, exp_black, exp_eval);
         hold = next_rand() % 11;
         for (int i = 0; i < hold; i++)
         begin
            board_valid = (i == 0);    // Ignored in wait for clear
            @(negedge clk);
            if (!eval_valid)
            begin
               timing_errors++;
               $display("eval_valid dropped before clear_eval");
            end
            check_outputs(exp_white, exp_black, exp_eval);
         end
         board_valid = 1'b0;
         clear_eval  = 1'b1;
         @(negedge clk);
         clear_eval = 1'b0;
         if (eval_valid)
         begin
            timing_errors++;
            $display("eval_valid still high one cycle after clear_eval");
         end
      end
   endtask

   initial
   begin
      rng_state         = 32'd78255;
      reset             = 1'b1;
      board_valid       = 1'b0;
      is_attacking_done = 1'b0;
      clear_eval        = 1'b0;
      board_in          = '0;
      value_errors      = 0;
      timing_errors     = 0;
      timed_out         = 1'b0;
      repeat (4) @(negedge clk);      // Reset over 4 rising edges
      reset = 1'b0;
      for (int i = 0; i < 10; i++)
      begin
         @(negedge clk);
         if (eval_valid)
         begin
            timing_errors++;
            $display("eval_valid high after reset with no board");
         end
      end
      for (int n = 0; n < 200 && !timed_out; n++)
         run_board(random_board(0));
      for (int n = 0; n < 20 && !timed_out; n++)
         run_board(random_board(1)); // Phase clamp boards
      $display("Value errors: %0d, timing errors: %0d", value_errors, timing_errors);
      if (value_errors == 0 && timing_errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

// ==== project.f ====
verilog/eval_pkg.sv
verilog/eval_term_if.sv
verilog/eval_sequencer.sv
verilog/material_eval.sv
verilog/pawn_eval.sv
verilog/taper_pipeline.sv
verilog/eval_top.sv
tb/eval_props.sv
tb/eval_tb.sv

// ==== run.sh ====
#!/bin/bash
# Build and run the testbench with Verilator, pass only on the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module eval_tb \
   -f project.f -o eval_sim \
   && ./obj_dir/eval_sim | tee /dev/stderr | grep -qx "Done: no errors" \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
